//--- common/frame_pkg.sv
`default_nettype none

package frame_pkg;

	// ------------------------------
	// widths
	// ------------------------------
	localparam int DATA_WD        = 64;	// bus and fifo word
	localparam int REG_WD         = 32;	// size registers
	localparam int BYTES_PER_WORD = 8;

	// payload buffer
	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_AW    = 4;	// log2 of depth

	// ------------------------------
	// frame sizes in bytes
	// ------------------------------
	localparam logic [REG_WD-1:0] LEADER_BYTES        = 32'd56;	// 7 words
	localparam logic [REG_WD-1:0] TRAILER_BYTES       = 32'd32;	// 4 words
	localparam logic [REG_WD-1:0] TRAILER_CHUNK_BYTES = 32'd40;	// extra chunk word

	// header identification
	localparam logic [31:0] LEADER_MAGIC  = 32'h4C56_3355;	// "U3VL" little endian
	localparam logic [31:0] TRAILER_MAGIC = 32'h5456_3355;	// "U3VT" little endian
	localparam logic [15:0] LEADER_KIND   = 16'h0001;	// image payload type

	// ------------------------------
	// phase codes, one-hot
	// ------------------------------
	// bit 0 leader, bit 1 payload, bit 2 trailer
	localparam logic [2:0] PH_IDLE    = 3'b000;
	localparam logic [2:0] PH_LEADER  = 3'b001;
	localparam logic [2:0] PH_PAYLOAD = 3'b010;
	localparam logic [2:0] PH_TRAILER = 3'b100;

	// wishbone address per phase
	localparam logic [1:0] ADR_LEADER  = 2'd1;
	localparam logic [1:0] ADR_PAYLOAD = 2'd2;
	localparam logic [1:0] ADR_TRAILER = 2'd3;

	// packet former fsm
	localparam logic [1:0] FMR_IDLE  = 2'd0;	// waiting for a new phase flag
	localparam logic [1:0] FMR_ISSUE = 2'd1;	// stb low, next word being set up
	localparam logic [1:0] FMR_ACK   = 2'd2;	// stb high until ack

	// ------------------------------
	// first header word
	// ------------------------------
	// same slot, decoded as leader or trailer
	// magic sits in the upper half of the word
	typedef union packed {
		struct packed {
			logic [31:0] magic;
			logic [15:0] block_id;
			logic [15:0] kind;	// payload type
		} leader;
		struct packed {
			logic [31:0] magic;
			logic [15:0] block_id;
			logic [15:0] status;	// bit 0 = chunk mode
		} trailer;
	} hdr_word_u;

endpackage

`default_nettype wire

//--- dv/frame_golden.txt
// one record per test, seven hex words each, after a leading test count
// chunk mode, payload bytes, frame count, valid percent, payload base, leader word 0 template, trailer magic
// leader template is {magic, block_id 0, kind}; payload word k = base + k * 0001_0000_0000_0001
00000000_00000004
// test 1, chunk off, 64 bytes, one frame
00000000_00000000 00000000_00000040 00000000_00000001 00000000_00000050
1000_2000_3000_0000 4C563355_00000001 00000000_54563355
// test 2, chunk on, trailer grows to 5 words
00000000_00000001 00000000_00000040 00000000_00000001 00000000_00000050
2000_3000_4000_0000 4C563355_00000001 00000000_54563355
// test 3, three back to back frames
00000000_00000000 00000000_00000020 00000000_00000003 00000000_00000046
3000_4000_5000_0000 4C563355_00000001 00000000_54563355
// test 4, 256 bytes, larger than the fifo, slow source
00000000_00000000 00000000_00000100 00000000_00000001 00000000_0000003C
4000_5000_6000_0000 4C563355_00000001 00000000_54563355

//--- dv/tb_usb3_frame_tx.sv
`timescale 1ns/1ps
`default_nettype none

module tb_usb3_frame_tx;

	logic        clk;
	logic        reset;
	logic        i_chunkmodeactive;
	logic [31:0] iv_payload_size;
	logic [63:0] i_data;
	logic        i_data_valid;
	logic        i_wb_ack;
	wire         o_data_ready;
	wire         o_wb_cyc;
	wire         o_wb_stb;
	wire         o_wb_we;
	wire  [1:0]  o_wb_adr;
	wire  [63:0] o_wb_dat;

	logic [63:0] golden [0:63];	// test records
	logic [65:0] expect_q [$];	// {adr, dat} per write
	integer      seed;
	int          src_idx;
	int          src_total;
	int          valid_pct;
	bit          src_active;
	logic [63:0] pay_base;
	bit          busy;	// slave holding a write
	int          delay;
	int          cycles;
	int          limit;

	usb3_frame_tx u_dut
	(
		.clk               (clk),
		.reset             (reset),
		.i_chunkmodeactive (i_chunkmodeactive),
		.iv_payload_size   (iv_payload_size),
		.i_data            (i_data),
		.i_data_valid      (i_data_valid),
		.o_data_ready      (o_data_ready),
		.o_wb_cyc          (o_wb_cyc),
		.o_wb_stb          (o_wb_stb),
		.o_wb_we           (o_wb_we),
		.o_wb_adr          (o_wb_adr),
		.o_wb_dat          (o_wb_dat),
		.i_wb_ack          (i_wb_ack)
	);

	always #20 clk = ~clk;	// 40 ns period

	function automatic logic [63:0] payload_word(input int k);
		return pay_base + 64'(k) * 64'h0001_0000_0000_0001;
	endfunction

	task automatic check_value(input string what, input logic [65:0] got,
			input logic [65:0] exp);
		if (got !== exp)
		begin
			$display("** Error at %0t ns: %s got %h expected %h", $time, what, got, exp);
			$display("TEST FAILED");
			$fatal(1, "write mismatch");
		end
	endtask

	// ------------------------------
	// payload source
	// ------------------------------
	always @(posedge clk)
	begin
		if (!src_active)
			i_data_valid <= 1'b0;
		else
		begin
			if (i_data_valid && o_data_ready)
				src_idx = src_idx + 1;	// word taken on this edge
			if (i_data_valid && !o_data_ready)
				i_data_valid <= 1'b1;	// hold under back-pressure
			else if (src_idx < src_total && int'({$random(seed)} % 100) < valid_pct)
			begin
				i_data       <= payload_word(src_idx);
				i_data_valid <= 1'b1;
			end
			else
				i_data_valid <= 1'b0;
		end
	end

	// ------------------------------
	// wishbone slave and checker
	// ------------------------------
	always @(posedge clk)
	begin
		if (reset)
		begin
			i_wb_ack <= 1'b0;
			busy = 0;
		end
		else if (i_wb_ack)
		begin
			// cyc, stb and we all high on the completing edge
			check_value("cyc stb we", {o_wb_cyc, o_wb_stb, o_wb_we}, 3'b111);
			if (expect_q.size() == 0)
			begin
				$display("a write arrived with no expected entry left");
				$display("TEST FAILED");
				$fatal(1, "unexpected write");
			end
			else
				check_value("write", {o_wb_adr, o_wb_dat}, expect_q.pop_front());
			i_wb_ack <= 1'b0;
			busy = 0;
		end
		else if (o_wb_stb)
		begin
			if (!busy)
			begin
				busy = 1;
				delay = int'({$random(seed)} % 4);	// 0 to 3 extra cycles
			end
			if (delay == 0)
				i_wb_ack <= 1'b1;
			else
				delay = delay - 1;
		end
	end

	// watchdog
	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (limit != 0 && cycles > limit)
		begin
			$display("run did not finish within %0d cycles, %0d writes still expected",
				limit, expect_q.size());
			$display("TEST FAILED");
			$fatal(1, "timeout");
		end
	end

	// expected writes of one test, from the framing rules
	task automatic build_expect(input bit chunk, input int bytes, input int frames,
			input logic [63:0] lead_tpl, input logic [31:0] t_magic);
		int wpf;
		logic [63:0] w;
		wpf = bytes / 8;
		for (int f = 0; f < frames; f++)
		begin
			w = lead_tpl | {32'd0, 16'(f), 16'd0};
			expect_q.push_back({2'd1, w});
			// size word only known after a payload phase
			expect_q.push_back({2'd1, (f == 0) ? 64'd0 : 64'(bytes)});
			for (int i = 0; i < 5; i++)
				expect_q.push_back({2'd1, 64'd0});
			for (int k = 0; k < wpf; k++)
				expect_q.push_back({2'd2, payload_word(f * wpf + k)});
			expect_q.push_back({2'd3, t_magic, 16'(f), 15'd0, chunk});
			expect_q.push_back({2'd3, 64'(bytes)});
			for (int i = 0; i < (chunk ? 3 : 2); i++)
				expect_q.push_back({2'd3, 64'd0});	// padding, chunk word zero
		end
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------
	initial
	begin
		int ntests;
		int base;
		bit chunk;
		int bytes;
		int frames;
		clk               = 1'b0;
		reset             = 1'b1;
		i_chunkmodeactive = 1'b0;
		iv_payload_size   = '0;
		i_data            = '0;
		i_data_valid      = 1'b0;
		i_wb_ack          = 1'b0;
		seed       = 22;
		src_idx    = 0;
		src_total  = 0;
		src_active = 0;
		cycles     = 0;
		limit      = 0;
		$readmemh("dv/frame_golden.txt", golden);
		ntests = int'(golden[0]);
		for (int t = 0; t < ntests; t++)	// writes times 8 plus 200 per test
		begin
			base  = 1 + t * 7;
			chunk = golden[base][0];
			limit = limit + 200 + 8 * int'(golden[base + 2]) *
				(7 + int'(golden[base + 1]) / 8 + (chunk ? 5 : 4));
		end
		for (int t = 0; t < ntests; t++)
		begin
			base      = 1 + t * 7;
			chunk     = golden[base][0];
			bytes     = int'(golden[base + 1]);
			frames    = int'(golden[base + 2]);
			@(posedge clk);
			src_active = 0;
			reset             <= 1'b1;	// config sampled in reset
			i_chunkmodeactive <= chunk;
			iv_payload_size   <= 32'(bytes);
			valid_pct = int'(golden[base + 3]);
			pay_base  = golden[base + 4];
			src_idx   = 0;
			src_total = frames * bytes / 8;
			build_expect(chunk, bytes, frames, golden[base + 5], golden[base + 6][31:0]);
			repeat (16) @(posedge clk);
			reset <= 1'b0;
			src_active = 1;
			while (src_idx < src_total || expect_q.size() != 0)
				@(posedge clk);
			repeat (6) @(posedge clk);	// any stray write fails in the slave
		end
		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- dv/usb3_frame_tx_assert.sv
`timescale 1ns/1ps
`default_nettype none

module usb3_frame_tx_assert
(
	input wire                             clk,
	input wire                             reset,
	input wire                             i_leader_flag,
	input wire                             i_payload_flag,
	input wire                             i_trailer_flag,
	input wire                             o_change_flag,
	input wire                             o_wb_cyc,
	input wire                             o_wb_stb,
	input wire [1:0]                       o_wb_adr,
	input wire [frame_pkg::DATA_WD-1:0]    o_wb_dat,
	input wire                             i_wb_ack
);

	// ------------------------------
	// bus rules
	// ------------------------------
	stb_in_cyc: assert property (@(posedge clk) disable iff (reset)
		o_wb_stb |-> o_wb_cyc)
		else $error("stb high outside cyc");

	// held while the slave stalls
	stable_wait: assert property (@(posedge clk) disable iff (reset)
		(o_wb_stb && !i_wb_ack) |=> ($stable(o_wb_adr) && $stable(o_wb_dat)))
		else $error("address or data moved before ack");

	// phase rules
	one_phase: assert property (@(posedge clk) disable iff (reset)
		$onehot0({i_trailer_flag, i_payload_flag, i_leader_flag}))
		else $error("more than one phase flag");

	change_pulse: assert property (@(posedge clk) disable iff (reset)
		o_change_flag |=> !o_change_flag)
		else $error("change flag longer than one cycle");

endmodule

bind packet_former usb3_frame_tx_assert u_assert
(
	.clk            (clk),
	.reset          (reset),
	.i_leader_flag  (i_leader_flag),
	.i_payload_flag (i_payload_flag),
	.i_trailer_flag (i_trailer_flag),
	.o_change_flag  (o_change_flag),
	.o_wb_cyc       (o_wb_cyc),
	.o_wb_stb       (o_wb_stb),
	.o_wb_adr       (o_wb_adr),
	.o_wb_dat       (o_wb_dat),
	.i_wb_ack       (i_wb_ack)
);

`default_nettype wire

//--- hdl/frame_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module frame_fifo
(
	input  wire                             clk,
	input  wire                             reset,
	input  wire [frame_pkg::DATA_WD-1:0]    i_data,
	input  wire                             i_data_valid,
	output logic                            o_data_ready,
	input  wire                             i_pop,
	output logic [frame_pkg::DATA_WD-1:0]   o_data,
	output logic                            o_empty
);

	// storage
	logic [frame_pkg::DATA_WD-1:0] mem [frame_pkg::FIFO_DEPTH];

	logic [frame_pkg::FIFO_AW-1:0] wr_ptr;
	logic [frame_pkg::FIFO_AW-1:0] rd_ptr;
	logic [frame_pkg::FIFO_AW:0]   count;	// one extra bit for full

	logic push;
	logic pop;

	// ------------------------------
	// flags
	// ------------------------------
	assign o_data_ready = (count != frame_pkg::FIFO_DEPTH);	// low only when full
	assign o_empty      = (count == '0);
	assign o_data       = mem[rd_ptr];	// head of queue, fall-through

	assign push = i_data_valid & o_data_ready;
	assign pop  = i_pop & ~o_empty;	// pop on empty dropped

	// ------------------------------
	// pointers and count
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;	// wraps at depth
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// both or none
			endcase
		end
	end

	// payload words, no reset needed
	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= i_data;
	end

endmodule

`default_nettype wire

//--- hdl/packet_switch.sv
`timescale 1ns/1ps
`default_nettype none

module packet_switch
(
	input  wire                             clk,
	input  wire                             reset,

	// configuration, sampled in reset
	input  wire                             i_chunkmodeactive,
	input  wire                             i_framebuffer_empty,
	input  wire [frame_pkg::REG_WD-1:0]     iv_payload_size,	// bytes, multiple of 8

	// phase handshake with the former
	input  wire                             i_change_flag,	// last ack of a phase
	output logic                            o_leader_flag,
	output logic                            o_payload_flag,
	output logic                            o_trailer_flag,
	output logic                            o_chunkmodeactive,
	output logic [frame_pkg::REG_WD-1:0]    ov_packet_size
);

	logic [2:0]                    current_state;
	logic [2:0]                    next_state;
	logic [frame_pkg::REG_WD-1:0]  payload_size_reg;

	// ------------------------------
	// config capture
	// ------------------------------
	// held while reset is high, frozen afterwards
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			o_chunkmodeactive <= i_chunkmodeactive;
			payload_size_reg  <= iv_payload_size;
		end
	end

	// ------------------------------
	// phase fsm
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
			current_state <= frame_pkg::PH_IDLE;
		else
			current_state <= next_state;
	end

	always_comb
	begin
		next_state = current_state;
		case (current_state)
			frame_pkg::PH_IDLE:
			begin
				if (!i_framebuffer_empty)	// first payload word in, start the frame
					next_state = frame_pkg::PH_LEADER;
			end
			frame_pkg::PH_LEADER:
			begin
				if (i_change_flag)
					next_state = frame_pkg::PH_PAYLOAD;
			end
			frame_pkg::PH_PAYLOAD:
			begin
				if (i_change_flag)
					next_state = frame_pkg::PH_TRAILER;
			end
			frame_pkg::PH_TRAILER:
			begin
				if (i_change_flag)
					next_state = frame_pkg::PH_IDLE;	// frame done
			end
			default: next_state = frame_pkg::PH_IDLE;
		endcase
	end

	// flags and size follow next_state, so they land on the state edge
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			o_leader_flag  <= 1'b0;
			o_payload_flag <= 1'b0;
			o_trailer_flag <= 1'b0;
			ov_packet_size <= '0;
		end
		else
		begin
			o_leader_flag  <= next_state[0];
			o_payload_flag <= next_state[1];
			o_trailer_flag <= next_state[2];
			case (next_state)
				frame_pkg::PH_LEADER:  ov_packet_size <= frame_pkg::LEADER_BYTES;
				frame_pkg::PH_PAYLOAD: ov_packet_size <= payload_size_reg;
				frame_pkg::PH_TRAILER:
				begin
					if (o_chunkmodeactive)
						ov_packet_size <= frame_pkg::TRAILER_CHUNK_BYTES;	// chunk word added
					else
						ov_packet_size <= frame_pkg::TRAILER_BYTES;
				end
				default: ov_packet_size <= '0;	// idle
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/usb3_frame_tx.sv
`timescale 1ns/1ps
`default_nettype none

module usb3_frame_tx
(
	input  wire                             clk,
	input  wire                             reset,

	// configuration, sampled in reset
	input  wire                             i_chunkmodeactive,
	input  wire [frame_pkg::REG_WD-1:0]     iv_payload_size,

	// payload source
	input  wire [frame_pkg::DATA_WD-1:0]    i_data,
	input  wire                             i_data_valid,
	output wire                             o_data_ready,

	// wishbone to the usb3 interface
	output wire                             o_wb_cyc,
	output wire                             o_wb_stb,
	output wire                             o_wb_we,
	output wire [1:0]                       o_wb_adr,
	output wire [frame_pkg::DATA_WD-1:0]    o_wb_dat,
	input  wire                             i_wb_ack
);

	// ------------------------------
	// internal nets
	// ------------------------------
	wire [frame_pkg::DATA_WD-1:0] fifo_data;
	wire                          fifo_empty;
	wire                          fifo_pop;
	wire                          leader_flag;
	wire                          payload_flag;
	wire                          trailer_flag;
	wire                          chunkmodeactive;	// frozen copy from the sequencer
	wire [frame_pkg::REG_WD-1:0]  packet_size;
	wire                          change_flag;

	frame_fifo u_frame_fifo
	(
		.clk          (clk),
		.reset        (reset),
		.i_data       (i_data),
		.i_data_valid (i_data_valid),
		.o_data_ready (o_data_ready),
		.i_pop        (fifo_pop),
		.o_data       (fifo_data),
		.o_empty      (fifo_empty)
	);

	packet_switch u_packet_switch
	(
		.clk                 (clk),
		.reset               (reset),
		.i_chunkmodeactive   (i_chunkmodeactive),
		.i_framebuffer_empty (fifo_empty),
		.iv_payload_size     (iv_payload_size),
		.i_change_flag       (change_flag),
		.o_leader_flag       (leader_flag),
		.o_payload_flag      (payload_flag),
		.o_trailer_flag      (trailer_flag),
		.o_chunkmodeactive   (chunkmodeactive),
		.ov_packet_size      (packet_size)
	);

	packet_former u_packet_former
	(
		.clk               (clk),
		.reset             (reset),
		.i_leader_flag     (leader_flag),
		.i_payload_flag    (payload_flag),
		.i_trailer_flag    (trailer_flag),
		.i_chunkmodeactive (chunkmodeactive),
		.iv_packet_size    (packet_size),
		.o_change_flag     (change_flag),
		.i_fifo_data       (fifo_data),
		.i_fifo_empty      (fifo_empty),
		.o_fifo_pop        (fifo_pop),
		.o_wb_cyc          (o_wb_cyc),
		.o_wb_stb          (o_wb_stb),
		.o_wb_we           (o_wb_we),
		.o_wb_adr          (o_wb_adr),
		.o_wb_dat          (o_wb_dat),
		.i_wb_ack          (i_wb_ack)
	);

endmodule

`default_nettype wire

//--- packet_former/packet_former.sv
`timescale 1ns/1ps
`default_nettype none

module packet_former
(
	input  wire                             clk,
	input  wire                             reset,

	// phase from the sequencer
	input  wire                             i_leader_flag,
	input  wire                             i_payload_flag,
	input  wire                             i_trailer_flag,
	input  wire                             i_chunkmodeactive,
	input  wire [frame_pkg::REG_WD-1:0]     iv_packet_size,
	output logic                            o_change_flag,

	// payload fifo drain side
	input  wire [frame_pkg::DATA_WD-1:0]    i_fifo_data,
	input  wire                             i_fifo_empty,
	output logic                            o_fifo_pop,

	// wishbone classic master, write only
	output logic                            o_wb_cyc,
	output logic                            o_wb_stb,
	output logic                            o_wb_we,
	output logic [1:0]                      o_wb_adr,
	output logic [frame_pkg::DATA_WD-1:0]   o_wb_dat,
	input  wire                             i_wb_ack
);

	logic [1:0]                    state;
	logic [2:0]                    flags;
	logic [2:0]                    flags_q;
	logic [2:0]                    rise;	// newly raised phase flag
	logic [1:0]                    ph_adr;	// latched phase of current packet
	logic [frame_pkg::REG_WD-1:0]  words_left;
	logic [2:0]                    hdr_idx;	// header word index
	logic [frame_pkg::REG_WD-1:0]  payload_bytes;
	logic [15:0]                   block_id;

	logic [1:0]                    cur_adr;
	logic [2:0]                    cur_idx;
	logic                          can_issue;
	logic                          launch;
	logic                          last_word;
	frame_pkg::hdr_word_u          hdr0;
	logic [frame_pkg::DATA_WD-1:0] next_dat;

	assign flags = {i_trailer_flag, i_payload_flag, i_leader_flag};
	assign rise  = flags & ~flags_q;

	// ------------------------------
	// word select
	// ------------------------------
	// in idle the phase comes straight from the rising flag
	always_comb
	begin
		if (state == frame_pkg::FMR_IDLE)
		begin
			cur_idx = '0;
			if (rise[0])
				cur_adr = frame_pkg::ADR_LEADER;
			else if (rise[1])
				cur_adr = frame_pkg::ADR_PAYLOAD;
			else
				cur_adr = frame_pkg::ADR_TRAILER;
		end
		else
		begin
			cur_adr = ph_adr;
			cur_idx = hdr_idx;
		end
	end

	// payload waits for a word at the fifo head
	assign can_issue = (cur_adr != frame_pkg::ADR_PAYLOAD) | ~i_fifo_empty;
	assign launch    = can_issue & ((state == frame_pkg::FMR_ISSUE) |
			((state == frame_pkg::FMR_IDLE) & (|rise)));
	assign last_word = (words_left == 1);

	// first header word, leader or trailer view
	always_comb
	begin
		hdr0 = '0;
		if (cur_adr == frame_pkg::ADR_TRAILER)
		begin
			hdr0.trailer.magic    = frame_pkg::TRAILER_MAGIC;
			hdr0.trailer.block_id = block_id;
			hdr0.trailer.status   = {15'd0, i_chunkmodeactive};
		end
		else
		begin
			hdr0.leader.magic    = frame_pkg::LEADER_MAGIC;
			hdr0.leader.block_id = block_id;
			hdr0.leader.kind     = frame_pkg::LEADER_KIND;
		end
	end

	always_comb
	begin
		if (cur_adr == frame_pkg::ADR_PAYLOAD)
			next_dat = i_fifo_data;
		else if (cur_idx == 3'd0)
			next_dat = hdr0;
		else if (cur_idx == 3'd1)	// size of the last payload phase seen
			next_dat = {{(frame_pkg::DATA_WD-frame_pkg::REG_WD){1'b0}}, payload_bytes};
		else
			next_dat = '0;	// padding and chunk word
	end

	// ------------------------------
	// control
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state         <= frame_pkg::FMR_IDLE;
			flags_q       <= '0;
			ph_adr        <= frame_pkg::ADR_LEADER;
			words_left    <= '0;
			hdr_idx       <= '0;
			payload_bytes <= '0;
			block_id      <= '0;
			o_wb_cyc      <= 1'b0;
			o_wb_stb      <= 1'b0;
		end
		else
		begin
			flags_q <= flags;
			case (state)
				frame_pkg::FMR_IDLE:
				begin
					if (|rise)
					begin
						ph_adr     <= cur_adr;
						words_left <= iv_packet_size / frame_pkg::BYTES_PER_WORD;
						hdr_idx    <= '0;
						if (rise[1])
							payload_bytes <= iv_packet_size;
						state <= launch ? frame_pkg::FMR_ACK : frame_pkg::FMR_ISSUE;
					end
				end
				frame_pkg::FMR_ISSUE:
				begin
					if (launch)
						state <= frame_pkg::FMR_ACK;
				end
				frame_pkg::FMR_ACK:
				begin
					if (i_wb_ack)
					begin
						words_left <= words_left - 1'b1;
						if (ph_adr != frame_pkg::ADR_PAYLOAD)
							hdr_idx <= hdr_idx + 1'b1;
						if (last_word)
						begin
							o_wb_cyc <= 1'b0;	// end of packet
							state    <= frame_pkg::FMR_IDLE;
							if (ph_adr == frame_pkg::ADR_TRAILER)
								block_id <= block_id + 1'b1;	// next frame
						end
						else
							state <= frame_pkg::FMR_ISSUE;
					end
				end
				default: state <= frame_pkg::FMR_IDLE;
			endcase
			if (launch)
			begin
				o_wb_stb <= 1'b1;
				o_wb_cyc <= 1'b1;
			end
			else if (i_wb_ack)
				o_wb_stb <= 1'b0;	// at least one low cycle between writes
		end
	end

	// address and data held from stb rise to ack
	always_ff @(posedge clk)
	begin
		if (launch)
		begin
			o_wb_adr <= cur_adr;
			o_wb_dat <= next_dat;
		end
	end

	assign o_wb_we       = o_wb_cyc;	// write only master
	assign o_fifo_pop    = o_wb_stb & i_wb_ack & (ph_adr == frame_pkg::ADR_PAYLOAD);
	assign o_change_flag = o_wb_stb & i_wb_ack & last_word;

endmodule

`default_nettype wire

//--- project.f
common/frame_pkg.sv
hdl/frame_fifo.sv
hdl/packet_switch.sv
packet_former/packet_former.sv
hdl/usb3_frame_tx.sv
dv/usb3_frame_tx_assert.sv
dv/tb_usb3_frame_tx.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the frame transmit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-Wno-fatal \
	--top-module tb_usb3_frame_tx \
	-f project.f \
	-o sim_tb_usb3_frame_tx

# a $fatal in the testbench gives a non-zero exit status
./obj_dir/sim_tb_usb3_frame_tx
